//--- mfcc.f
+incdir+verif
hdl/mfcc_pkg.sv
hdl/sample_stream_if.sv
hdl/frame_window.sv
hdl/dft_power.sv
hdl/mel_filter_bank.sv
hdl/log_serializer.sv
hdl/mfcc.sv
verif/mfcc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MFCC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mfcc.f --top-module mfcc_tb -o mfcc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mfcc_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- verif/mfcc_model.svh
`ifndef MFCC_MODEL_SVH
`define MFCC_MODEL_SVH

// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

////////////////////////////////////////////////////////////
// Reference arithmetic
////////////////////////////////////////////////////////////

function automatic sample_t window_sample(input sample_t s, input int n);
    longint p;
    p = longint'(s) * longint'(window_rom[n]);
    return sample_t'(p >>> 15);
endfunction

function automatic power_t bin_power(input sample_t w [frame_len], input int k);
    longint re;
    longint im;
    re = 0;
    im = 0;
    for (int n = 0; n < frame_len; n++) begin
        re += longint'(w[n]) * longint'(cos_rom[(k * n) % frame_len]);
        im += longint'(w[n]) * longint'(sin_rom[(k * n) % frame_len]);
    end
    re = re >>> 16;
    im = im >>> 16;
    return power_t'((re * re + im * im) >> 8);
endfunction

function automatic power_t band_energy(input power_t pw [num_bins], input int band);
    longint acc;
    acc = 0;
    for (int k = 0; k < num_bins; k++) begin
        acc += longint'(mel_rom[band][k]) * longint'(pw[k]);
    end
    acc = acc >> 8;
    // Clip to 32 bits
    if (acc > 64'sh0000_0000_ffff_ffff) begin
        return '1;
    end
    return power_t'(acc);
endfunction

// Leading-one position over the next 8 bits down
function automatic feature_t log2_feature(input power_t e);
    int         msb;
    logic [7:0] frac;
    if (e == '0) begin
        return '0;
    end
    msb = 0;
    for (int i = 0; i < 32; i++) begin
        if (e[i]) begin
            msb = i;
        end
    end
    frac = '0;
    for (int j = 0; j < 8; j++) begin
        if (msb - 1 - j >= 0) begin
            frac[7 - j] = e[msb - 1 - j];
        end
    end
    return {3'b000, msb[4:0], frac};
endfunction

function automatic void frame_features(input sample_t stim [$], input int start,
                                       output feature_t f [num_bands]);
    sample_t w  [frame_len];
    power_t  pw [num_bins];
    for (int n = 0; n < frame_len; n++) begin
        w[n] = window_sample(stim[start + n], n);
    end
    for (int k = 0; k < num_bins; k++) begin
        pw[k] = bin_power(w, k);
    end
    for (int b = 0; b < num_bands; b++) begin
        f[b] = log2_feature(band_energy(pw, b));
    end
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_feature(input feature_t got, input feature_t exp, input int idx);
    if (got !== exp) begin
        feature_errors++;
        $display("[FAIL] time %0t: feature %0d is %h, expected %h", $time, idx, got, exp);
    end
endtask

task automatic check_last(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        last_errors++;
        $display("[FAIL] time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

//--- verif/mfcc_tb.sv
`timescale 1ns/1ps

module mfcc_tb import mfcc_pkg::*; ();

    localparam int stride         = 8;
    localparam int num_random     = 72;
    localparam int num_const      = 16;
    localparam int num_samples    = num_random + 2 * num_const;
    localparam int num_frames     = 1 + (num_samples - frame_len) / stride;
    localparam int zero_frame     = num_random / stride;
    localparam int timeout_cycles = num_frames * 400 + 2000;

    logic     clk;
    logic     arst_n;
    sample_t  s_axis_tdata;
    logic     s_axis_tvalid;
    logic     s_axis_tready;
    feature_t m_axis_tdata;
    logic     m_axis_tvalid;
    logic     m_axis_tready;
    logic     m_axis_tlast;

    logic [31:0] rng;
    sample_t     stim  [$];
    feature_t    exp_q [$];
    int          feature_errors = 0;
    int          last_errors    = 0;
    int          other_errors   = 0;
    int          cycle_cnt;

    `include "mfcc_model.svh"

    mfcc #(.STRIDE(stride)) dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random samples, then an all-zero frame, then a full-scale frame
    task automatic build_stimulus();
        for (int i = 0; i < num_random; i++) begin
            rng = xorshift(rng);
            stim.push_back(sample_t'(rng[15:0]));
        end
        for (int i = 0; i < num_const; i++) begin
            stim.push_back(16'sh0000);
        end
        for (int i = 0; i < num_const; i++) begin
            stim.push_back(16'sh7fff);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Traffic and checking, one edge at a time
    ////////////////////////////////////////////////////////////
    task automatic run_traffic();
        int sent;
        int received;
        sent     = 0;
        received = 0;
        while (received < num_frames * num_bands) begin
            @(posedge clk);
            if (m_axis_tvalid && m_axis_tready) begin
                check_feature(m_axis_tdata, exp_q[received], received);
                if (received / num_bands == zero_frame) begin
                    check_feature(m_axis_tdata, '0, received);
                end
                check_last(m_axis_tlast, (received % num_bands) == num_bands - 1,
                           $sformatf("m_axis_tlast at feature %0d", received));
                received++;
            end
            if (s_axis_tvalid && s_axis_tready) begin
                sent++;
            end
            // Hold a pending sample until it is taken
            if (!s_axis_tvalid || s_axis_tready) begin
                rng = xorshift(rng);
                if (sent < num_samples && rng[1:0] != 2'b00) begin
                    s_axis_tvalid <= 1'b1;
                    s_axis_tdata  <= stim[sent];
                end else begin
                    s_axis_tvalid <= 1'b0;
                end
            end
            rng = xorshift(rng);
            m_axis_tready <= (rng[1:0] != 2'b00);
        end
    endtask

    task automatic check_no_extra();
        m_axis_tready <= 1'b1;
        repeat (200) begin
            @(posedge clk);
            if (m_axis_tvalid) begin
                other_errors++;
                $display("Unexpected extra feature after the last frame at time %0t", $time);
            end
        end
    endtask

    initial begin
        feature_t feats [num_bands];
        arst_n        = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        rng           = 32'hecf7_4bd5;
        build_stimulus();
        for (int fr = 0; fr < num_frames; fr++) begin
            frame_features(stim, fr * stride, feats);
            for (int b = 0; b < num_bands; b++) begin
                exp_q.push_back(feats[b]);
            end
        end
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_last(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
        check_last(s_axis_tready, 1'b1, "s_axis_tready after reset");
        run_traffic();
        check_no_extra();
        $display("Errors: feature %0d, last %0d, other %0d",
                 feature_errors, last_errors, other_errors);
        if (feature_errors + last_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

//--- hdl/mfcc.sv
`timescale 1ns/1ps

module mfcc import mfcc_pkg::*; #(
    parameter int STRIDE = 8
) (
    input  logic     clk,
    input  logic     arst_n,
    input  sample_t  s_axis_tdata,
    input  logic     s_axis_tvalid,
    output logic     s_axis_tready,
    output feature_t m_axis_tdata,
    output logic     m_axis_tvalid,
    input  logic     m_axis_tready,
    output logic     m_axis_tlast
);

    // Windowed samples, bin powers, band energies
    sample_stream_if #(.data_t(sample_t)) win_if ();
    sample_stream_if #(.data_t(power_t))  pow_if ();
    sample_stream_if #(.data_t(power_t))  band_if ();

    frame_window #(.STRIDE(STRIDE)) u_frame_window (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (s_axis_tdata),
        .in_valid (s_axis_tvalid),
        .in_ready (s_axis_tready),
        .out      (win_if.source)
    );

    dft_power u_dft_power (
        .clk    (clk),
        .arst_n (arst_n),
        .in     (win_if.sink),
        .out    (pow_if.source)
    );

    mel_filter_bank u_mel_filter_bank (
        .clk    (clk),
        .arst_n (arst_n),
        .in     (pow_if.sink),
        .out    (band_if.source)
    );

    log_serializer u_log_serializer (
        .clk    (clk),
        .arst_n (arst_n),
        .in     (band_if.sink),
        .data   (m_axis_tdata),
        .valid  (m_axis_tvalid),
        .ready  (m_axis_tready),
        .last   (m_axis_tlast)
    );

endmodule

//--- hdl/log_serializer.sv
`timescale 1ns/1ps

module log_serializer import mfcc_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    sample_stream_if.sink in,
    output feature_t      data,
    output logic          valid,
    input  logic          ready,
    output logic          last
);

    logic accept;

    // Leading-one index over the 8 bits just below it
    function automatic feature_t log_feature(input power_t e);
        logic [4:0] pos;
        power_t     norm;
        pos = '0;
        for (int i = 0; i < 32; i++) begin
            if (e[i]) begin
                pos = 5'(i);
            end
        end
        // Move the leading one up to bit 31
        norm = e << (5'd31 - pos);
        return (e == '0) ? '0 : {3'b000, pos, norm[30:23]};
    endfunction

    // Take a new band when the register is free or draining
    assign in.ready = !valid || ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            data <= log_feature(in.data);
            last <= in.last;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (accept) begin
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

endmodule

//--- hdl/mel_filter_bank.sv
`timescale 1ns/1ps

module mel_filter_bank import mfcc_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    sample_stream_if.sink   in,
    sample_stream_if.source out
);

    mel_state_t  state;
    logic [3:0]  bin_cnt;
    logic [1:0]  band_cnt;
    logic [39:0] acc_q    [num_bands];
    logic [39:0] acc_next [num_bands];

    function automatic logic [39:0] sat_add(input logic [39:0] a, input logic [39:0] b);
        logic [40:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[40] ? '1 : sum[39:0];
    endfunction

    assign in.ready = (state == mel_gather);

    // Every band picks up its share of the incoming bin
    always_comb begin
        for (int b = 0; b < num_bands; b++) begin
            acc_next[b] = sat_add((bin_cnt == 4'd0) ? 40'd0 : acc_q[b],
                                  40'(mel_rom[b][bin_cnt]) * 40'(in.data));
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            for (int b = 0; b < num_bands; b++) begin
                acc_q[b] <= acc_next[b];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Gather bins, then emit bands in order
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= mel_gather;
            bin_cnt  <= '0;
            band_cnt <= '0;
        end else begin
            case (state)
                mel_gather: begin
                    if (in.valid) begin
                        bin_cnt <= bin_cnt + 4'd1;
                        if (in.last) begin
                            bin_cnt  <= '0;
                            band_cnt <= '0;
                            state    <= mel_emit;
                        end
                    end
                end
                mel_emit: begin
                    if (out.ready) begin
                        band_cnt <= band_cnt + 2'd1;
                        if (band_cnt == 2'(num_bands - 1)) begin
                            state <= mel_gather;
                        end
                    end
                end
                default: state <= mel_gather;
            endcase
        end
    end

    assign out.data  = acc_q[band_cnt][39:8];
    assign out.valid = (state == mel_emit);
    assign out.last  = (band_cnt == 2'(num_bands - 1));

endmodule

//--- hdl/dft_power.sv
`timescale 1ns/1ps

module dft_power import mfcc_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    sample_stream_if.sink   in,
    sample_stream_if.source out
);

    dft_state_t         state;
    sample_t            frame_mem [frame_len];
    logic [3:0]         ld_cnt;
    logic [3:0]         n_cnt;
    logic [3:0]         bin;
    logic [3:0]         idx;
    logic signed [35:0] acc_re;
    logic signed [35:0] acc_im;
    logic signed [31:0] prod_re;
    logic signed [31:0] prod_im;
    logic signed [35:0] re_sum;
    logic signed [35:0] im_sum;
    logic signed [19:0] re_sh;
    logic signed [19:0] im_sh;
    logic signed [39:0] re_sq;
    logic signed [39:0] im_sq;
    logic [40:0]        pwr_sum;
    power_t             pwr_q;

    assign in.ready = (state == dft_load);

    // One MAC per cycle, restarting at sample 0 of every bin
    assign prod_re = frame_mem[n_cnt] * cos_rom[idx];
    assign prod_im = frame_mem[n_cnt] * sin_rom[idx];
    assign re_sum  = (n_cnt == 4'd0) ? 36'(prod_re) : acc_re + 36'(prod_re);
    assign im_sum  = (n_cnt == 4'd0) ? 36'(prod_im) : acc_im + 36'(prod_im);

    // Power from the final sums
    assign re_sh   = re_sum[35:16];
    assign im_sh   = im_sum[35:16];
    assign re_sq   = re_sh * re_sh;
    assign im_sq   = im_sh * im_sh;
    assign pwr_sum = {1'b0, re_sq} + {1'b0, im_sq};

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            frame_mem[ld_cnt] <= in.data;
        end
        if (state == dft_accumulate) begin
            acc_re <= re_sum;
            acc_im <= im_sum;
            if (n_cnt == 4'(frame_len - 1)) begin
                pwr_q <= pwr_sum[39:8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= dft_load;
            ld_cnt <= '0;
            n_cnt  <= '0;
            bin    <= '0;
            idx    <= '0;
        end else begin
            case (state)
                dft_load: begin
                    if (in.valid) begin
                        ld_cnt <= ld_cnt + 4'd1;
                        if (in.last) begin
                            ld_cnt <= '0;
                            bin    <= '0;
                            n_cnt  <= '0;
                            idx    <= '0;
                            state  <= dft_accumulate;
                        end
                    end
                end
                dft_accumulate: begin
                    n_cnt <= n_cnt + 4'd1;
                    // Table index is bin times sample, mod 16
                    idx   <= idx + bin;
                    if (n_cnt == 4'(frame_len - 1)) begin
                        state <= dft_output;
                    end
                end
                dft_output: begin
                    if (out.ready) begin
                        if (bin == 4'(num_bins - 1)) begin
                            state <= dft_load;
                        end else begin
                            bin   <= bin + 4'd1;
                            n_cnt <= '0;
                            idx   <= '0;
                            state <= dft_accumulate;
                        end
                    end
                end
                default: state <= dft_load;
            endcase
        end
    end

    assign out.data  = pwr_q;
    assign out.valid = (state == dft_output);
    assign out.last  = (bin == 4'(num_bins - 1));

endmodule

//--- hdl/frame_window.sv
`timescale 1ns/1ps

module frame_window import mfcc_pkg::*; #(
    parameter int STRIDE = 8
) (
    input  logic            clk,
    input  logic            arst_n,
    input  sample_t         in_data,
    input  logic            in_valid,
    output logic            in_ready,
    sample_stream_if.source out
);

    frame_state_t       state;
    sample_t            samples_q [frame_len];
    logic [4:0]         need;
    logic [3:0]         rd_idx;
    logic               accept;
    logic signed [32:0] win_prod;

    assign in_ready = (state == fw_fill);
    assign accept   = in_valid && in_ready;

    // Sample history, oldest in slot 0
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < frame_len - 1; i++) begin
                samples_q[i] <= samples_q[i + 1];
            end
            samples_q[frame_len - 1] <= in_data;
        end
    end

    // Count down new samples until the next frame is due
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= fw_fill;
            need   <= 5'(frame_len);
            rd_idx <= '0;
        end else begin
            case (state)
                fw_fill: begin
                    if (accept) begin
                        need <= need - 5'd1;
                        if (need == 5'd1) begin
                            state <= fw_emit;
                        end
                    end
                end
                fw_emit: begin
                    if (out.ready) begin
                        rd_idx <= rd_idx + 4'd1;
                        if (rd_idx == 4'(frame_len - 1)) begin
                            state <= fw_fill;
                            need  <= 5'(STRIDE);
                        end
                    end
                end
                default: state <= fw_fill;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Windowing, oldest sample first
    ////////////////////////////////////////////////////////////
    assign win_prod  = samples_q[rd_idx] * $signed({1'b0, window_rom[rd_idx]});
    assign out.data  = win_prod[30:15];
    assign out.valid = (state == fw_emit);
    assign out.last  = (rd_idx == 4'(frame_len - 1));

endmodule

//--- hdl/sample_stream_if.sv
`timescale 1ns/1ps

interface sample_stream_if #(
    parameter type data_t = logic [15:0]
);

    logic  valid;
    logic  ready;
    data_t data;
    logic  last;

    // Held by the source until valid and ready meet
    modport source (output valid, data, last, input ready);
    modport sink (input valid, data, last, output ready);

endinterface

//--- hdl/mfcc_pkg.sv
package mfcc_pkg;

    localparam int frame_len = 16;
    localparam int num_bins  = 9;
    localparam int num_bands = 4;

    typedef logic signed [15:0] sample_t;
    typedef logic [31:0]        power_t;
    typedef logic [15:0]        feature_t;

    typedef enum logic {fw_fill, fw_emit} frame_state_t;
    typedef enum logic [1:0] {dft_load, dft_accumulate, dft_output} dft_state_t;
    typedef enum logic {mel_gather, mel_emit} mel_state_t;

    ////////////////////////////////////////////////////////////
    // Coefficient tables
    ////////////////////////////////////////////////////////////

    // Hamming window, unsigned Q1.15
    localparam logic [15:0] window_rom [frame_len] = '{
        16'd2621,  16'd3925,  16'd7609,  16'd13037,
        16'd19270, 16'd25231, 16'd29889, 16'd32439,
        16'd32439, 16'd29889, 16'd25231, 16'd19270,
        16'd13037, 16'd7609,  16'd3925,  16'd2621
    };

    // One period of cosine and sine, signed Q1.15
    localparam logic signed [15:0] cos_rom [frame_len] = '{
        16'sd32767,  16'sd30274,  16'sd23170,  16'sd12540,
        16'sd0,      -16'sd12540, -16'sd23170, -16'sd30274,
        -16'sd32767, -16'sd30274, -16'sd23170, -16'sd12540,
        16'sd0,      16'sd12540,  16'sd23170,  16'sd30274
    };

    localparam logic signed [15:0] sin_rom [frame_len] = '{
        16'sd0,      16'sd12540,  16'sd23170,  16'sd30274,
        16'sd32767,  16'sd30274,  16'sd23170,  16'sd12540,
        16'sd0,      -16'sd12540, -16'sd23170, -16'sd30274,
        -16'sd32767, -16'sd30274, -16'sd23170, -16'sd12540
    };

    // Triangular mel weights, Q0.8, one row per band
    localparam logic [7:0] mel_rom [num_bands][num_bins] = '{
        '{8'd128, 8'd255, 8'd128, 8'd0,   8'd0,   8'd0,   8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd128, 8'd255, 8'd128, 8'd0,   8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd0,   8'd0,   8'd128, 8'd255, 8'd170, 8'd85,  8'd0},
        '{8'd0,   8'd0,   8'd0,   8'd0,   8'd0,   8'd0,   8'd85,  8'd170, 8'd255}
    };

endpackage
